// File: dv/colorMapperTb.sv
module colorMapperTb
    import colorMapperPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int PRIORITY_PIXELS = 1500;
    localparam int SPRITE_PIXELS   = 1000;
    localparam int PALETTE_PIXELS  = 64; // 32 frog plus 32 car
    localparam int GEOM_PIXELS     = 108;
    localparam int DRAIN_PIXELS    = 2;
    localparam int TOTAL_PIXELS    = RESET_CYCLES + PRIORITY_PIXELS + SPRITE_PIXELS +
                                     PALETTE_PIXELS + GEOM_PIXELS + DRAIN_PIXELS;
    localparam int WATCHDOG_NS     = (TOTAL_PIXELS + 100) * CLK_PERIOD;

    logic       Clk;
    logic       rstN;
    pixelPos_t  pos;
    overlayIn_t overlay;
    laneHits_t  carHits;
    laneHits_t  logHits;
    laneData_t  carData;
    laneData_t  logData;
    goalIn_t    goal;
    rgb_t       vga;

    logic [23:0] expQ[$]; // one entry per driven pixel

    colorMapper dut
    (
        .Clk     (Clk),
        .rstN    (rstN),
        .pos     (pos),
        .overlay (overlay),
        .carHits (carHits),
        .logHits (logHits),
        .carData (carData),
        .logData (logData),
        .goal    (goal),
        .vga     (vga)
    );

    initial
    begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: pixel pipeline did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic checkValue(input string name, input logic [23:0] actual,
                              input logic [23:0] expected);
        if (actual !== expected)
        begin
            $display("ERR %s: got 0x%06h, expected 0x%06h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [23:0] paletteColor(input logic [PAL_IDX_W-1:0] idx);
        if (int'(idx) < PALETTE_SIZE)
        begin
            return PALETTE[idx];
        end
        return COLOR_BLACK; // beyond the table
    endfunction

    // lowest lane with any slot bit wins and a bad vector gives index 0
    function automatic spriteHit_t pickSprite(input laneHits_t hits, input laneData_t data);
        spriteHit_t res;
        res = '0;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            if (!res.hit && (hits.slot[l] != '0))
            begin
                res.hit = 1'b1;
                if ($countones(hits.slot[l]) == 1)
                begin
                    for (int s = 0; s < SLOTS_PER_LANE; s++)
                    begin
                        if (hits.slot[l][s])
                        begin
                            res.index = data.index[l][s];
                        end
                    end
                end
            end
        end
        return res;
    endfunction

    function automatic logic [23:0] modelPixel(input pixelPos_t p, input overlayIn_t o,
                                               input laneHits_t ch, input laneData_t cd,
                                               input laneHits_t lh, input laneData_t ld,
                                               input goalIn_t g);
        spriteHit_t carSel;
        spriteHit_t logSel;
        logic       outside;
        carSel  = pickSprite(ch, cd);
        logSel  = pickSprite(lh, ld);
        outside = (p.x <= 10'd124) || (p.x >= 10'd544) || (p.y <= 10'd75) || (p.y >= 10'd440);
        if (o.isFont)                          return COLOR_WHITE;
        if (o.isFrog && (o.frogIndex != '0))   return paletteColor(o.frogIndex);
        if (o.timerOn)                         return o.timerLit ? COLOR_TIMER : COLOR_BLACK;
        if (outside)                           return COLOR_BORDER;
        if (carSel.hit)                        return (carSel.index != '0) ?
                                                      paletteColor(carSel.index) : COLOR_BLACK;
        if (logSel.hit)                        return (logSel.index != '0) ?
                                                      paletteColor(logSel.index) : COLOR_WATER;
        if (g.isFinish != '0)                  return ((g.isFinish & g.frogFinished) != '0) ?
                                                      COLOR_GOAL_DONE : COLOR_GOAL_OPEN;
        if (p.y < 10'd244)                     return COLOR_WATER;
        return COLOR_BLACK;
    endfunction

    // vga at this negedge belongs to the pixel driven two edges back
    task automatic compareOutput();
        logic [23:0] expected;
        if (expQ.size() > 2)
        begin
            expected = expQ.pop_front();
            checkValue("vga", vga, expected);
        end
    endtask

    task automatic applyPixel(input pixelPos_t p, input overlayIn_t o, input laneHits_t ch,
                              input laneData_t cd, input laneHits_t lh, input laneData_t ld,
                              input goalIn_t g);
        @(posedge Clk);
        rstN    <= 1'b1;
        pos     <= p;
        overlay <= o;
        carHits <= ch;
        carData <= cd;
        logHits <= lh;
        logData <= ld;
        goal    <= g;
        expQ.push_back(modelPixel(p, o, ch, cd, lh, ld, g));
        @(negedge Clk);
        compareOutput();
    endtask

    function automatic laneData_t randomLaneData(input int zeroOdds);
        laneData_t d;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            for (int s = 0; s < SLOTS_PER_LANE; s++)
            begin
                d.index[l][s] = ($urandom_range(zeroOdds - 1) == 0) ? '0 : PAL_IDX_W'($urandom);
            end
        end
        return d;
    endfunction

    // mostly one-hot lanes with the odd raw vector that may be invalid
    function automatic laneHits_t randomHits(input int activeOdds);
        laneHits_t h;
        h = '0;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            if ($urandom_range(activeOdds - 1) == 0)
            begin
                if ($urandom_range(3) == 0)
                begin
                    h.slot[l] = SLOTS_PER_LANE'($urandom);
                end
                else
                begin
                    h.slot[l][$urandom_range(SLOTS_PER_LANE - 1)] = 1'b1;
                end
            end
        end
        return h;
    endfunction

    task automatic runPriority();
        pixelPos_t  p;
        overlayIn_t o;
        goalIn_t    g;
        repeat (PRIORITY_PIXELS)
        begin
            p.x            = 10'($urandom_range(639));
            p.y            = 10'($urandom_range(479));
            o.isFont       = ($urandom_range(9) == 0);
            o.isFrog       = ($urandom_range(5) == 0);
            o.frogIndex    = PAL_IDX_W'($urandom);
            o.timerOn      = ($urandom_range(7) == 0);
            o.timerLit     = 1'($urandom);
            g.isFinish     = ($urandom_range(3) == 0) ? 5'($urandom) : 5'd0;
            g.frogFinished = 5'($urandom);
            applyPixel(p, o, randomHits(6), randomLaneData(4), randomHits(6),
                       randomLaneData(4), g);
        end
    endtask

    task automatic runSprites();
        pixelPos_t p;
        goalIn_t   g;
        repeat (SPRITE_PIXELS)
        begin
            p.x = 10'($urandom_range(543, 125));
            p.y = 10'($urandom_range(439, 76));
            g   = ($urandom_range(4) == 0) ? goalIn_t'($urandom) : '0;
            applyPixel(p, '0, randomHits(3), randomLaneData(3), randomHits(3),
                       randomLaneData(3), g);
        end
    endtask

    task automatic runPalette();
        pixelPos_t  p;
        overlayIn_t o;
        laneHits_t  ch;
        laneData_t  cd;
        int         lane;
        int         slot;
        for (int idx = 0; idx < 32; idx++)
        begin
            p.x         = 10'($urandom_range(543, 125));
            p.y         = 10'($urandom_range(439, 76));
            o           = '0;
            o.isFrog    = 1'b1;
            o.frogIndex = PAL_IDX_W'(idx);
            applyPixel(p, o, '0, '0, '0, '0, '0);
            lane                = $urandom_range(NUM_LANES - 1);
            slot                = $urandom_range(SLOTS_PER_LANE - 1);
            ch                  = '0;
            ch.slot[lane][slot] = 1'b1;
            cd                  = randomLaneData(2);
            cd.index[lane][slot] = PAL_IDX_W'(idx);
            p.y                 = 10'($urandom_range(439, 245)); // road rows
            applyPixel(p, '0, ch, cd, '0, '0, '0);
        end
    endtask

    task automatic runGeometry();
        int        xs[9];
        int        ys[12];
        pixelPos_t p;
        xs = '{0, 123, 124, 125, 300, 543, 544, 545, 639};
        ys = '{0, 74, 75, 76, 200, 243, 244, 245, 439, 440, 441, 479};
        foreach (xs[i])
        begin
            foreach (ys[j])
            begin
                p.x = 10'(xs[i]);
                p.y = 10'(ys[j]);
                applyPixel(p, '0, '0, '0, '0, '0, '0);
            end
        end
    endtask

    initial
    begin
        rstN     = 1'b0;
        pos      = '0;
        overlay  = '0;
        carHits  = '0;
        logHits  = '0;
        carData  = '0;
        logData  = '0;
        goal     = '0;
        void'($urandom(2550));
        repeat (RESET_CYCLES)
        begin
            @(posedge Clk);
            rstN <= 1'b0;
            expQ.push_back(COLOR_BLACK); // pipe is cleared
            @(negedge Clk);
            compareOutput();
        end
        runPriority();
        runSprites();
        runPalette();
        runGeometry();
        repeat (DRAIN_PIXELS)
        begin
            applyPixel('0, '0, '0, '0, '0, '0, '0);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: dv/colorMapper_sva.sv
module colorMapperSva
    import colorMapperPkg::*;
(
    input logic       Clk,
    input logic       rstN,
    input pixelPos_t  pos,
    input overlayIn_t overlay,
    input rgb_t       vga
);
    timeunit 1ns;
    timeprecision 1ps;

    logic outsideField;
    logic noTopLayer;

    assign outsideField = (pos.x <= FIELD_LEFT) || (pos.x >= FIELD_RIGHT) ||
                          (pos.y <= FIELD_TOP)  || (pos.y >= FIELD_BOTTOM);
    assign noTopLayer   = !overlay.isFont && !overlay.isFrog && !overlay.timerOn;

    resetBlack: assert property (@(posedge Clk) !rstN |-> ##2 (vga == 24'h000000))
        else $error("vga not black two cycles after reset");

    // reset in the middle cycle clears the pipe
    fontWhite: assert property (@(posedge Clk)
        (rstN && overlay.isFont) |-> ##2 (!$past(rstN) || (vga == 24'hffffff)))
        else $error("font pixel did not come out white");

    borderGray: assert property (@(posedge Clk)
        (rstN && outsideField && noTopLayer) |-> ##2 (!$past(rstN) || (vga == 24'h979797)))
        else $error("border pixel did not come out gray");

endmodule

bind colorMapper colorMapperSva sva
(
    .Clk     (Clk),
    .rstN    (rstN),
    .pos     (pos),
    .overlay (overlay),
    .vga     (vga)
);

// File: hw/colorMapper.sv
module colorMapper
    import colorMapperPkg::*;
(
    input  logic       Clk,
    input  logic       rstN,
    input  pixelPos_t  pos,
    input  overlayIn_t overlay,
    input  laneHits_t  carHits,
    input  laneHits_t  logHits,
    input  laneData_t  carData,
    input  laneData_t  logData,
    input  goalIn_t    goal,
    output rgb_t       vga
);

    spriteHit_t carHit;
    spriteHit_t logHit;
    pixelCmd_t  cmd;

    // lane selectors are combinational, same cycle as pos
    laneSpriteSelect carSelect
    (
        .hits (carHits),
        .data (carData),
        .sel  (carHit)
    );

    laneSpriteSelect logSelect
    (
        .hits (logHits),
        .data (logData),
        .sel  (logHit)
    );

    // stage 1
    pixelLayerControl layerCtrl
    (
        .Clk     (Clk),
        .rstN    (rstN),
        .pos     (pos),
        .overlay (overlay),
        .car     (carHit),
        .log     (logHit),
        .goal    (goal),
        .cmd     (cmd)
    );

    // stage 2
    pixelColorStage colorStage
    (
        .Clk  (Clk),
        .rstN (rstN),
        .cmd  (cmd),
        .vga  (vga)
    );

endmodule

// File: hw/colorMapperPkg.sv
package colorMapperPkg;

    localparam int NUM_LANES      = 5;
    localparam int SLOTS_PER_LANE = 4; // one-hot per lane
    localparam int PAL_IDX_W      = 5;
    localparam int PALETTE_SIZE   = 21;

    // play field bounds, inclusive border on each edge
    localparam logic [9:0] FIELD_LEFT   = 10'd124;
    localparam logic [9:0] FIELD_RIGHT  = 10'd544;
    localparam logic [9:0] FIELD_TOP    = 10'd75;
    localparam logic [9:0] FIELD_BOTTOM = 10'd440;
    localparam logic [9:0] WATER_LINE   = 10'd244; // rows above are river

    localparam logic [23:0] COLOR_WHITE     = 24'hffffff;
    localparam logic [23:0] COLOR_TIMER     = 24'hfcd703;
    localparam logic [23:0] COLOR_BORDER    = 24'h979797;
    localparam logic [23:0] COLOR_WATER     = 24'h0000ff;
    localparam logic [23:0] COLOR_GOAL_DONE = 24'h00ff00;
    localparam logic [23:0] COLOR_GOAL_OPEN = 24'hff0000;
    localparam logic [23:0] COLOR_BLACK     = 24'h000000;

    // sprite palette, entry 0 is never drawn as a sprite
    localparam logic [23:0] PALETTE [PALETTE_SIZE] = '{
        24'hff0000, 24'hffe0a8, 24'hffe0a8, 24'h4b3100, 24'hffe0a8,
        24'hffe0a8, 24'hfcfcfc, 24'haeacae, 24'h398802, 24'h398802,
        24'h398802, 24'h398802, 24'hf0bc3c, 24'haeacae, 24'h3a3701,
        24'h6c6c01, 24'h398802, 24'h7ec50e, 24'h398802, 24'h65b0ff,
        24'h65b0ff
    };

    typedef enum logic [2:0] {
        FILL_BLACK,
        FILL_FONT,
        FILL_TIMER,
        FILL_BORDER,
        FILL_WATER,
        FILL_GOAL_DONE,
        FILL_GOAL_OPEN,
        FILL_SPRITE
    } pixelFill_e;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } pixelPos_t;

    typedef struct packed {
        logic                 isFont;
        logic                 isFrog;
        logic                 timerOn;
        logic                 timerLit; // lit part of the bar
        logic [PAL_IDX_W-1:0] frogIndex;
    } overlayIn_t;

    typedef struct packed {
        logic [NUM_LANES-1:0][SLOTS_PER_LANE-1:0] slot;
    } laneHits_t;

    typedef struct packed {
        logic [NUM_LANES-1:0][SLOTS_PER_LANE-1:0][PAL_IDX_W-1:0] index;
    } laneData_t;

    typedef struct packed {
        logic [4:0] isFinish;
        logic [4:0] frogFinished;
    } goalIn_t;

    typedef struct packed {
        logic                 hit;
        logic [PAL_IDX_W-1:0] index;
    } spriteHit_t;

    typedef struct packed {
        pixelFill_e           fill;
        logic [PAL_IDX_W-1:0] index;
    } pixelCmd_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage

// File: hw/laneSpriteSelect.sv
module laneSpriteSelect
    import colorMapperPkg::*;
(
    input  laneHits_t  hits,
    input  laneData_t  data,
    output spriteHit_t sel
);

    logic [SLOTS_PER_LANE-1:0]                winVec;
    logic [SLOTS_PER_LANE-1:0][PAL_IDX_W-1:0] winData;
    logic                                     isOneHot;

    // scan down so the lowest active lane is written last
    always_comb
    begin
        winVec  = '0;
        winData = '0;
        for (int l = NUM_LANES - 1; l >= 0; l--)
        begin
            if (hits.slot[l] != '0)
            begin
                winVec  = hits.slot[l];
                winData = data.index[l];
            end
        end
    end

    // exactly one slot bit set
    assign isOneHot = (winVec != '0) && ((winVec & (winVec - 1'b1)) == '0);

    always_comb
    begin
        sel.hit   = |hits.slot;
        sel.index = '0; // bad slot vector reads as index 0
        if (isOneHot)
        begin
            for (int s = 0; s < SLOTS_PER_LANE; s++)
            begin
                if (winVec[s])
                begin
                    sel.index = winData[s];
                end
            end
        end
    end

endmodule

// File: hw/pixelColorStage.sv
module pixelColorStage
    import colorMapperPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  pixelCmd_t cmd,
    output rgb_t      vga
);

    logic [23:0] nextColor;

    always_comb
    begin
        case (cmd.fill)
            FILL_FONT:
            begin
                nextColor = COLOR_WHITE;
            end
            FILL_TIMER:
            begin
                nextColor = COLOR_TIMER;
            end
            FILL_BORDER:
            begin
                nextColor = COLOR_BORDER;
            end
            FILL_WATER:
            begin
                nextColor = COLOR_WATER;
            end
            FILL_GOAL_DONE:
            begin
                nextColor = COLOR_GOAL_DONE;
            end
            FILL_GOAL_OPEN:
            begin
                nextColor = COLOR_GOAL_OPEN;
            end
            FILL_SPRITE:
            begin
                if (cmd.index < PALETTE_SIZE)
                begin
                    nextColor = PALETTE[cmd.index];
                end
                else
                begin
                    nextColor = COLOR_BLACK; // past the end of the table
                end
            end
            default:
            begin
                nextColor = COLOR_BLACK;
            end
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            vga <= '0;
        end
        else
        begin
            vga <= nextColor;
        end
    end

endmodule

// File: hw/pixelLayerControl.sv
module pixelLayerControl
    import colorMapperPkg::*;
(
    input  logic       Clk,
    input  logic       rstN,
    input  pixelPos_t  pos,
    input  overlayIn_t overlay,
    input  spriteHit_t car,
    input  spriteHit_t log,
    input  goalIn_t    goal,
    output pixelCmd_t  cmd
);

    logic      isBorder;
    logic      anyGoal;
    logic      goalDone;
    logic      isWater;
    pixelCmd_t nextCmd;

    // outside the play field on any side
    assign isBorder = (pos.x <= FIELD_LEFT) || (pos.x >= FIELD_RIGHT) ||
                      (pos.y <= FIELD_TOP)  || (pos.y >= FIELD_BOTTOM);

    assign anyGoal  = |goal.isFinish;
    assign goalDone = |(goal.isFinish & goal.frogFinished); // frog sits in this slot
    assign isWater  = pos.y < WATER_LINE;

    // first matching layer wins, top to bottom
    always_comb
    begin
        nextCmd.fill  = FILL_BLACK;
        nextCmd.index = '0;
        if (overlay.isFont)
        begin
            nextCmd.fill = FILL_FONT;
        end
        else if (overlay.isFrog && (overlay.frogIndex != '0)) // index 0 is see-through
        begin
            nextCmd.fill  = FILL_SPRITE;
            nextCmd.index = overlay.frogIndex;
        end
        else if (overlay.timerOn)
        begin
            if (overlay.timerLit)
            begin
                nextCmd.fill = FILL_TIMER;
            end
            else
            begin
                nextCmd.fill = FILL_BLACK; // spent part of the bar
            end
        end
        else if (isBorder)
        begin
            nextCmd.fill = FILL_BORDER;
        end
        else if (car.hit)
        begin
            if (car.index != '0)
            begin
                nextCmd.fill  = FILL_SPRITE;
                nextCmd.index = car.index;
            end
            else
            begin
                nextCmd.fill = FILL_BLACK; // road shows between cars
            end
        end
        else if (log.hit)
        begin
            if (log.index != '0)
            begin
                nextCmd.fill  = FILL_SPRITE;
                nextCmd.index = log.index;
            end
            else
            begin
                nextCmd.fill = FILL_WATER; // river shows between logs
            end
        end
        else if (anyGoal)
        begin
            if (goalDone)
            begin
                nextCmd.fill = FILL_GOAL_DONE;
            end
            else
            begin
                nextCmd.fill = FILL_GOAL_OPEN;
            end
        end
        else if (isWater)
        begin
            nextCmd.fill = FILL_WATER;
        end
        else
        begin
            nextCmd.fill = FILL_BLACK;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            cmd.fill  <= FILL_BLACK;
            cmd.index <= '0;
        end
        else
        begin
            cmd <= nextCmd;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the color mapper testbench, pass is read from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module colorMapperTb -Mdir obj_dir &&
./obj_dir/VcolorMapperTb | tee /dev/stderr | grep "TEST PASSED" > /dev/null &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}

// File: src.f
hw/colorMapperPkg.sv
hw/laneSpriteSelect.sv
hw/pixelLayerControl.sv
hw/pixelColorStage.sv
hw/colorMapper.sv
dv/colorMapper_sva.sv
dv/colorMapperTb.sv
